/* cpu_core.f */
+incdir+common
common/rv_isa_pkg.sv
common/core_bus_pkg.sv
common/mem_req_if.sv
core/reg_file.sv
core/instr_decoder.sv
core/alu.sv
core/core_sequencer.sv
hdl/mem_access.sv
hdl/cpu_core.sv
sim/cpu_core_assert.sv
sim/tb_cpu_core.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_cpu_core
FILELIST = cpu_core.f
BUILD    = obj_dir
LOG      = sim.log
RUN_ARGS = +verilator+error+limit+1000
FAIL_MSG = TESTBENCH FAILED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* sim/tb_cpu_core.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module tb_cpu_core;

    localparam int NUM_CHECKS      = 17;
    localparam int WATCHDOG_CYCLES = NUM_CHECKS * 200;

    // major opcodes for the I-type helper
    localparam int OPC_IMM  = 'h13;
    localparam int OPC_LOAD = 'h03;
    localparam int OPC_JALR = 'h67;

    logic             clk;
    logic             rst          = 1'b1;
    logic             mem_req_o;
    logic             mem_we_o;
    logic [`XLEN-1:0] mem_addr_o;
    logic [`XLEN-1:0] mem_wdata_o;
    logic             mem_full_i   = 1'b0;
    logic [`XLEN-1:0] mem_rdata_i  = '0;
    logic             mem_rvalid_i = 1'b0;

    logic [`XLEN-1:0] mem [256];       // 1 KiB, program from address 0
    logic [`XLEN-1:0] store_addr_q [$];
    logic [`XLEN-1:0] store_data_q [$];
    logic [`XLEN-1:0] rd_addr;
    logic [`XLEN-1:0] first_addr;
    logic             first_we;
    logic             seen_req = 1'b0;
    int               rd_wait  = -1;   // cycles until rvalid, -1 when idle
    int               prog_len = 0;
    int               errors   = 0;
    integer           seed     = 66;

    // expected stores in program order, not-taken branch markers only
    string exp_name [$] = '{"add", "sub", "xor", "or", "and", "sll", "srl", "addi", "lui",
                            "lw_back", "x0_zero", "beq_not_taken", "bne_not_taken",
                            "blt_not_taken", "bge_not_taken", "jal_link", "jalr_link"};
    logic [`XLEN-1:0] exp_addr [$] = '{
        32'h200, 32'h204, 32'h208, 32'h20C, 32'h210, 32'h214, 32'h218, 32'h21C, 32'h220,
        32'h224, 32'h228, 32'h230, 32'h238, 32'h240, 32'h248, 32'h250, 32'h258};
    logic [`XLEN-1:0] exp_data [$] = '{
        32'h0000_0004, 32'h0000_000A, 32'hFFFF_FFFA, 32'hFFFF_FFFF, 32'h0000_0005,
        32'hFFFF_FE80, 32'h01FF_FFFF, 32'hFFFF_FF99, 32'hABCD_E000, 32'hABCD_E000,
        32'h0000_0000, 32'h0000_0007, 32'h0000_0007, 32'h0000_0007, 32'h0000_0007,
        32'h0000_00AC, 32'h0000_00BC};

    cpu_core uut (
        .clk          (clk),
        .rst          (rst),
        .mem_req_o    (mem_req_o),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_full_i   (mem_full_i),
        .mem_rdata_i  (mem_rdata_i),
        .mem_rvalid_i (mem_rvalid_i)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // instruction encoders, fields in assembly order
    function automatic logic [31:0] r_type(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(int op, int f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] s_type(int rs2, int rs1, int imm); // sw only
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(int f3, int rs1, int rs2, int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(int rd, int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic logic [31:0] u_type(int rd, int imm20); // lui
        return {imm20[19:0], rd[4:0], 7'b0110111};
    endfunction

    task automatic emit(input logic [31:0] word);
        mem[prog_len[7:0]] = word;
        prog_len = prog_len + 1;
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            errors = errors + 1;
        end
    endtask

    // bus model, busy about one cycle in four
    always @(posedge clk) begin
        mem_full_i   <= (($random(seed) & 3) == 0);
        mem_rvalid_i <= 1'b0;
        if (mem_req_o && !seen_req) begin
            first_addr = mem_addr_o;
            first_we   = mem_we_o;
            seen_req   = 1'b1;
        end
        if (mem_req_o && !mem_full_i) begin
            if (mem_we_o) begin
                mem[mem_addr_o[9:2]] = mem_wdata_o;
                store_addr_q.push_back(mem_addr_o);
                store_data_q.push_back(mem_wdata_o);
            end else begin
                rd_addr = mem_addr_o;
                rd_wait = $unsigned($random(seed)) % 4; // 0 to 3 idle cycles
            end
        end
        if (rd_wait == 0) begin
            mem_rvalid_i <= 1'b1;
            mem_rdata_i  <= mem[rd_addr[9:2]];
        end
        if (rd_wait >= 0) begin
            rd_wait = rd_wait - 1;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: only %0d of %0d stores seen", store_addr_q.size(), NUM_CHECKS);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i[7:0]] = 32'hDEAD_0000 | (i << 2);
        end
        emit(i_type(OPC_IMM, 0, 10, 0, 'h200));  // x10 data base
        emit(i_type(OPC_IMM, 0, 1, 0, 7));
        emit(i_type(OPC_IMM, 0, 2, 0, -3));
        emit(i_type(OPC_IMM, 0, 11, 0, 39));     // low five bits give 7
        emit(r_type(0, 0, 3, 1, 2));
        emit(s_type(3, 10, 0));
        emit(r_type('h20, 0, 4, 1, 2));
        emit(s_type(4, 10, 4));
        emit(r_type(0, 4, 5, 1, 2));
        emit(s_type(5, 10, 8));
        emit(r_type(0, 6, 6, 1, 2));
        emit(s_type(6, 10, 12));
        emit(r_type(0, 7, 7, 1, 2));
        emit(s_type(7, 10, 16));
        emit(r_type(0, 1, 8, 2, 11));
        emit(s_type(8, 10, 20));
        emit(r_type(0, 5, 9, 2, 11));
        emit(s_type(9, 10, 24));
        emit(i_type(OPC_IMM, 0, 12, 2, -100));
        emit(s_type(12, 10, 28));
        emit(u_type(13, 'hABCDE));
        emit(s_type(13, 10, 32));
        emit(i_type(OPC_LOAD, 2, 14, 10, 32));
        emit(s_type(14, 10, 36));
        emit(i_type(OPC_IMM, 0, 0, 1, 5));       // result must vanish
        emit(s_type(0, 10, 40));
        // taken then not taken for each compare, markers at odd slots
        emit(b_type(0, 1, 1, 8));
        emit(s_type(1, 10, 44));
        emit(b_type(0, 1, 2, 8));
        emit(s_type(1, 10, 48));
        emit(b_type(1, 1, 2, 8));
        emit(s_type(1, 10, 52));
        emit(b_type(1, 1, 1, 8));
        emit(s_type(1, 10, 56));
        emit(b_type(4, 2, 1, 8));                // -3 < 7 signed
        emit(s_type(1, 10, 60));
        emit(b_type(4, 1, 2, 8));
        emit(s_type(1, 10, 64));
        emit(b_type(5, 1, 2, 8));
        emit(s_type(1, 10, 68));
        emit(b_type(5, 2, 1, 8));
        emit(s_type(1, 10, 72));
        emit(j_type(16, 8));                     // at 0xA8
        emit(s_type(1, 10, 76));
        emit(s_type(16, 10, 80));
        emit(i_type(OPC_IMM, 0, 18, 0, 192));
        emit(i_type(OPC_JALR, 0, 19, 18, 1));    // at 0xB8, odd target rounds to 0xC0
        emit(s_type(1, 10, 84));
        emit(s_type(19, 10, 88));
        emit(j_type(0, 0));                      // park here

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        while (store_addr_q.size() < NUM_CHECKS) begin
            @(posedge clk);
        end

        check("first_fetch_addr", `RESET_PC, first_addr);
        check("first_fetch_we", 32'd0, {31'd0, first_we});
        for (int i = 0; i < NUM_CHECKS; i++) begin
            check({exp_name[i], " addr"}, exp_addr[i], store_addr_q[i]);
            check({exp_name[i], " data"}, exp_data[i], store_data_q[i]);
        end

        $display("errors: %0d mismatches, %0d assertion failures", errors,
                 uut.u_assert.fail_count);
        if (errors == 0 && uut.u_assert.fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* sim/cpu_core_assert.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module cpu_core_assert (
    input logic             clk,
    input logic             rst,
    input logic             req_i,
    input logic             we_i,
    input logic [`XLEN-1:0] addr_i,
    input logic [`XLEN-1:0] wdata_i,
    input logic             full_i
);
    int fail_count = 0; // violations so far

    no_req_in_reset: assert property (@(posedge clk) rst |-> !req_i)
        else begin
            fail_count++;
            $error("bus request while reset is high");
        end

    // request frozen while the bus is full
    hold_under_full: assert property (@(posedge clk) disable iff (rst)
        (req_i && full_i) |=> (req_i && $stable(addr_i) && $stable(we_i) && $stable(wdata_i)))
        else begin
            fail_count++;
            $error("bus request changed while the bus was full");
        end

    we_needs_req: assert property (@(posedge clk) disable iff (rst) we_i |-> req_i)
        else begin
            fail_count++;
            $error("write flag high without a request");
        end

endmodule

bind cpu_core cpu_core_assert u_assert (
    .clk     (clk),
    .rst     (rst),
    .req_i   (mem_req_o),
    .we_i    (mem_we_o),
    .addr_i  (mem_addr_o),
    .wdata_i (mem_wdata_o),
    .full_i  (mem_full_i)
);

/* hdl/cpu_core.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module cpu_core import rv_isa_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    output logic             mem_req_o,
    output logic             mem_we_o,
    output logic [`XLEN-1:0] mem_addr_o,
    output logic [`XLEN-1:0] mem_wdata_o,
    input  logic             mem_full_i,
    input  logic [`XLEN-1:0] mem_rdata_i,
    input  logic             mem_rvalid_i
);
    dec_instr_t       dec;
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] data_addr;
    logic             branch_taken;
    logic [`XLEN-1:0] jump_target;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic             rd_we;
    logic [`XLEN-1:0] rd_data;

    mem_req_if mem_bus ();

    core_sequencer u_seq (
        .clk            (clk),
        .rst            (rst),
        .dec_i          (dec),
        .instr_o        (instr),
        .alu_result_i   (alu_result),
        .mem_addr_i     (data_addr),
        .branch_taken_i (branch_taken),
        .jump_target_i  (jump_target),
        .rs2_data_i     (rs2_data),
        .pc_o           (pc),
        .rd_we_o        (rd_we),
        .rd_data_o      (rd_data),
        .mem            (mem_bus)
    );

    instr_decoder u_dec (
        .instr_i (instr),
        .dec_o   (dec)
    );

    reg_file u_rf (
        .clk        (clk),
        .rst        (rst),
        .rs1_i      (dec.rs1),
        .rs2_i      (dec.rs2),
        .rd_i       (dec.rd),
        .we_i       (rd_we),
        .wd_i       (rd_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    alu u_alu (
        .dec_i          (dec),
        .pc_i           (pc),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .alu_result_o   (alu_result),
        .mem_addr_o     (data_addr),
        .branch_taken_o (branch_taken),
        .jump_target_o  (jump_target)
    );

    mem_access u_mem (
        .clk          (clk),
        .rst          (rst),
        .mem          (mem_bus),
        .mem_req_o    (mem_req_o),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_full_i   (mem_full_i),
        .mem_rdata_i  (mem_rdata_i),
        .mem_rvalid_i (mem_rvalid_i)
    );

endmodule

/* hdl/mem_access.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module mem_access import core_bus_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    mem_req_if.mem_mp        mem,
    output logic             mem_req_o,
    output logic             mem_we_o,
    output logic [`XLEN-1:0] mem_addr_o,
    output logic [`XLEN-1:0] mem_wdata_o,
    input  logic             mem_full_i,
    input  logic [`XLEN-1:0] mem_rdata_i,
    input  logic             mem_rvalid_i
);
    typedef enum logic [1:0] {
        MA_IDLE,
        MA_REQ,     // waiting for the bus to take it
        MA_RD_WAIT  // accepted read, waiting for rvalid
    } ma_state_e;

    ma_state_e        state_q;
    logic             done_q;
    logic [`XLEN-1:0] rdata_q;
    logic             start;

    // sequencer still holds req during the done cycle, so skip that one
    assign start = (state_q == MA_IDLE) && mem.req && !done_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q   <= MA_IDLE;
            mem_req_o <= 1'b0;
            mem_we_o  <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                MA_IDLE: begin
                    if (start) begin
                        mem_req_o <= 1'b1;
                        mem_we_o  <= (mem.kind == KIND_WRITE);
                        state_q   <= MA_REQ;
                    end
                end
                MA_REQ: begin
                    if (!mem_full_i) begin // accepted on this edge
                        mem_req_o <= 1'b0;
                        mem_we_o  <= 1'b0;
                        if (mem_we_o) begin
                            done_q  <= 1'b1;
                            state_q <= MA_IDLE;
                        end else begin
                            state_q <= MA_RD_WAIT;
                        end
                    end
                end
                MA_RD_WAIT: begin
                    if (mem_rvalid_i) begin
                        done_q  <= 1'b1;
                        state_q <= MA_IDLE;
                    end
                end
                default: state_q <= MA_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mem_addr_o  <= mem.addr;
            mem_wdata_o <= mem.wdata;
        end
        if (state_q == MA_RD_WAIT && mem_rvalid_i) begin
            rdata_q <= mem_rdata_i;
        end
    end

    assign mem.done  = done_q;
    assign mem.rdata = rdata_q;

endmodule

/* core/core_sequencer.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module core_sequencer import rv_isa_pkg::*, core_bus_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  dec_instr_t       dec_i,
    output logic [`XLEN-1:0] instr_o,
    input  logic [`XLEN-1:0] alu_result_i,
    input  logic [`XLEN-1:0] mem_addr_i,
    input  logic             branch_taken_i,
    input  logic [`XLEN-1:0] jump_target_i,
    input  logic [`XLEN-1:0] rs2_data_i,
    output logic [`XLEN-1:0] pc_o,
    output logic             rd_we_o,
    output logic [`XLEN-1:0] rd_data_o,
    mem_req_if.seq_mp        mem
);
    seq_state_e       state_q;
    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] ir_q;
    logic [`XLEN-1:0] pc_next;
    logic             gap_q;   // idle cycle between a data access and the next fetch
    logic             mem_op;

    assign mem_op  = dec_i.is_load || dec_i.is_store;
    assign pc_next = branch_taken_i ? jump_target_i : pc_q + `PC_STEP;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= FETCH;
            pc_q    <= `RESET_PC;
            ir_q    <= '0; // decodes as a harmless op before the first fetch
            gap_q   <= 1'b0;
        end else begin
            gap_q <= 1'b0;
            case (state_q)
                FETCH: begin
                    if (mem.done) begin
                        ir_q    <= mem.rdata;
                        state_q <= EXEC;
                    end
                end
                EXEC: begin
                    if (mem_op) begin
                        state_q <= MEM;
                    end else begin
                        pc_q    <= pc_next;
                        state_q <= FETCH;
                    end
                end
                MEM: begin
                    if (mem.done) begin
                        pc_q    <= pc_q + `PC_STEP;
                        gap_q   <= 1'b1;
                        state_q <= FETCH;
                    end
                end
                default: state_q <= FETCH;
            endcase
        end
    end

    // request fields stay put for the whole state
    always_comb begin
        mem.req  = ((state_q == FETCH) && !gap_q) || (state_q == MEM);
        mem.kind = KIND_FETCH;
        mem.addr = pc_q;
        if (state_q == MEM) begin
            mem.kind = dec_i.is_store ? KIND_WRITE : KIND_READ;
            mem.addr = mem_addr_i;
        end
    end

    assign mem.wdata = rs2_data_i;

    // writeback: alu in EXEC, load data when MEM finishes
    assign rd_data_o = (state_q == MEM) ? mem.rdata : alu_result_i;
    assign rd_we_o   = dec_i.wr_reg &&
                       (((state_q == EXEC) && !mem_op) ||
                        ((state_q == MEM) && mem.done && dec_i.is_load));

    assign pc_o    = pc_q;
    assign instr_o = ir_q;

endmodule

/* core/alu.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module alu import rv_isa_pkg::*; (
    input  dec_instr_t       dec_i,
    input  logic [`XLEN-1:0] pc_i,
    input  logic [`XLEN-1:0] rs1_data_i,
    input  logic [`XLEN-1:0] rs2_data_i,
    output logic [`XLEN-1:0] alu_result_o,
    output logic [`XLEN-1:0] mem_addr_o,
    output logic             branch_taken_o,
    output logic [`XLEN-1:0] jump_target_o
);
    logic [`XLEN-1:0] op2;
    logic [`XLEN-1:0] rs1_plus_imm;
    logic             cond;

    assign op2          = dec_i.use_imm ? dec_i.imm : rs2_data_i;
    assign rs1_plus_imm = rs1_data_i + dec_i.imm;

    always_comb begin
        alu_result_o = '0;
        case (dec_i.opcode)
            OP_OP, OP_IMM: begin
                case (alu_funct_e'(dec_i.funct3))
                    ALU_ADD: alu_result_o = dec_i.sub ? rs1_data_i - op2 : rs1_data_i + op2;
                    ALU_XOR: alu_result_o = rs1_data_i ^ op2;
                    ALU_OR:  alu_result_o = rs1_data_i | op2;
                    ALU_AND: alu_result_o = rs1_data_i & op2;
                    ALU_SLL: alu_result_o = rs1_data_i << op2[4:0];
                    ALU_SRL: alu_result_o = rs1_data_i >> op2[4:0];
                    default: alu_result_o = '0;
                endcase
            end
            OP_JAL, OP_JALR: alu_result_o = pc_i + `PC_STEP; // link value
            OP_LUI:          alu_result_o = dec_i.imm;       // already shifted up
            default:         alu_result_o = '0;
        endcase
    end

    // signed compare as in the ISA
    always_comb begin
        case (branch_funct_e'(dec_i.funct3))
            BR_BEQ:  cond = (rs1_data_i == rs2_data_i);
            BR_BNE:  cond = (rs1_data_i != rs2_data_i);
            BR_BLT:  cond = ($signed(rs1_data_i) < $signed(rs2_data_i));
            BR_BGE:  cond = ($signed(rs1_data_i) >= $signed(rs2_data_i));
            default: cond = 1'b0;
        endcase
    end

    assign branch_taken_o = dec_i.is_jump || (dec_i.is_branch && cond);
    assign mem_addr_o     = rs1_plus_imm;

    // jalr clears bit 0, branch and jal are pc relative
    assign jump_target_o = (dec_i.opcode == OP_JALR) ?
                           {rs1_plus_imm[`XLEN-1:1], 1'b0} :
                           pc_i + dec_i.imm;

endmodule

/* core/instr_decoder.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module instr_decoder import rv_isa_pkg::*; (
    input  logic [`XLEN-1:0] instr_i,
    output dec_instr_t       dec_o
);
    opcode_e          opcode;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_j;
    logic [`XLEN-1:0] imm_u;

    assign opcode = opcode_e'(instr_i[6:0]);

    // immediates per format
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                    instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                    instr_i[20], instr_i[30:21], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};

    always_comb begin
        dec_o        = '0;
        dec_o.opcode = opcode;
        dec_o.funct3 = instr_i[14:12];
        case (opcode)
            OP_OP: begin
                dec_o.rd     = instr_i[11:7];
                dec_o.rs1    = instr_i[19:15];
                dec_o.rs2    = instr_i[24:20];
                dec_o.sub    = (instr_i[31:25] == 7'b0100000);
                dec_o.wr_reg = 1'b1;
            end
            OP_IMM, OP_LOAD, OP_JALR: begin
                dec_o.rd      = instr_i[11:7];
                dec_o.rs1     = instr_i[19:15];
                dec_o.imm     = imm_i;
                dec_o.use_imm = 1'b1;
                dec_o.wr_reg  = 1'b1;
                dec_o.is_load = (opcode == OP_LOAD);
                dec_o.is_jump = (opcode == OP_JALR);
            end
            OP_STORE: begin
                dec_o.rs1      = instr_i[19:15];
                dec_o.rs2      = instr_i[24:20];
                dec_o.imm      = imm_s;
                dec_o.use_imm  = 1'b1;
                dec_o.is_store = 1'b1;
            end
            OP_BRANCH: begin
                dec_o.rs1       = instr_i[19:15];
                dec_o.rs2       = instr_i[24:20];
                dec_o.imm       = imm_b; // compare uses rs2, not imm
                dec_o.is_branch = 1'b1;
            end
            OP_JAL: begin
                dec_o.rd      = instr_i[11:7];
                dec_o.imm     = imm_j;
                dec_o.use_imm = 1'b1;
                dec_o.wr_reg  = 1'b1;
                dec_o.is_jump = 1'b1;
            end
            OP_LUI: begin
                dec_o.rd      = instr_i[11:7];
                dec_o.imm     = imm_u;
                dec_o.use_imm = 1'b1;
                dec_o.wr_reg  = 1'b1;
            end
            default: dec_o.funct3 = 3'b000; // unknown opcode runs as a no-op
        endcase
    end

endmodule

/* core/reg_file.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  logic [`REG_AW-1:0] rs1_i,
    input  logic [`REG_AW-1:0] rs2_i,
    input  logic [`REG_AW-1:0] rd_i,
    input  logic               we_i,
    input  logic [`XLEN-1:0]   wd_i,
    output logic [`XLEN-1:0]   rs1_data_o,
    output logic [`XLEN-1:0]   rs2_data_o
);
    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin // x0 never written
            regs[rd_i] <= wd_i;
        end
    end

    assign rs1_data_o = regs[rs1_i];
    assign rs2_data_o = regs[rs2_i];

endmodule

/* common/mem_req_if.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

interface mem_req_if import core_bus_pkg::*; ();

    logic             req;    // held until done
    mem_kind_e        kind;
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] wdata;
    logic             done;   // single cycle pulse
    logic [`XLEN-1:0] rdata;

    modport seq_mp (
        output req, kind, addr, wdata,
        input  done, rdata
    );

    modport mem_mp (
        input  req, kind, addr, wdata,
        output done, rdata
    );

endinterface

/* common/core_bus_pkg.sv */
package core_bus_pkg;

    // sequencer states
    typedef enum logic [1:0] {
        FETCH = 2'd0,
        EXEC  = 2'd1,
        MEM   = 2'd2
    } seq_state_e;

    // kind of memory transaction
    typedef enum logic [1:0] {
        KIND_FETCH = 2'd0,
        KIND_READ  = 2'd1,
        KIND_WRITE = 2'd2
    } mem_kind_e;

endpackage

/* common/rv_isa_pkg.sv */
`include "core_macros.svh"

package rv_isa_pkg;

    // supported major opcodes
    typedef enum logic [6:0] {
        OP_OP     = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000, // add, addi, sub
        ALU_SLL = 3'b001,
        ALU_XOR = 3'b100,
        ALU_SRL = 3'b101,
        ALU_OR  = 3'b110,
        ALU_AND = 3'b111
    } alu_funct_e;

    typedef enum logic [2:0] {
        BR_BEQ = 3'b000,
        BR_BNE = 3'b001,
        BR_BLT = 3'b100,
        BR_BGE = 3'b101
    } branch_funct_e;

    typedef struct packed {
        opcode_e                opcode;
        logic [2:0]             funct3;
        logic                   sub;      // R-type subtract
        logic [`REG_AW-1:0]     rd;
        logic [`REG_AW-1:0]     rs1;
        logic [`REG_AW-1:0]     rs2;
        logic [`XLEN-1:0]       imm;      // already sign extended
        logic                   use_imm;
        logic                   wr_reg;
        logic                   is_load;
        logic                   is_store;
        logic                   is_branch;
        logic                   is_jump;
    } dec_instr_t;

endpackage

/* common/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// datapath and bus width
`define XLEN 32

// architectural register count, x0 included
`define REG_COUNT 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// sequential pc increment
`define PC_STEP 32'd4

// register index width
`define REG_AW 5

`endif
